// ==== Bender.yml ====
package:
  name: mem_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/mem_pkg.sv
      - logic/mem_access_fsm.sv
      - logic/mem_wait_timer.sv
      - logic/dmem_bank.sv
      - logic/bank_select_mux.sv
      - logic/memwb_reg.sv
      - logic/mem_stage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/mem_stage_assert.sv
      - dv/tb_mem_stage.sv

// ==== dv/mem_stage_assert.sv ====
`timescale 1ns/1ps

`include "mem_config.svh"

module mem_stage_assert (
    input logic                clk,
    input logic                reset,
    input logic                m_mem_read,
    input logic                m_mem_write,
    input logic                m_mem_to_reg,
    input logic                m_reg_write,
    input mem_pkg::word_t      m_alu_out,
    input mem_pkg::word_t      m_mem_data,
    input mem_pkg::reg_idx_t   m_rd,
    input logic                stall_mem,
    input mem_pkg::word_t      wb_data,
    input mem_pkg::reg_idx_t   wb_rd,
    input logic                wb_reg_write,
    input mem_pkg::mem_state_e state
);

    localparam int SHADOW_WORDS = 4 * `DMEM_BANK_WORDS; // All four banks flattened

    mem_pkg::word_t              shadow    [SHADOW_WORDS]; // Last stored word per address
    logic                        shadow_ok [SHADOW_WORDS]; // Address has been stored
    logic [`DMEM_INDEX_BITS+1:0] addr_idx;                 // Index and bank bits together
    int                          err_count = 0;            // Read by the testbench

    // One-deep record of what MEM/WB should hold
    logic              exp_valid;
    logic              exp_load;   // Load word expected
    logic              exp_known;  // Expected word is defined
    logic              exp_rw;
    mem_pkg::reg_idx_t exp_rd;
    mem_pkg::word_t    exp_data;

    assign addr_idx = m_alu_out[`DMEM_INDEX_BITS+3:2];

    initial begin
        for (int i = 0; i < SHADOW_WORDS; i++) begin
            shadow_ok[i] = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            exp_valid <= 1'b0;
        end else begin
            exp_valid <= !stall_mem; // Stalled cycles carry no instruction
            if (!stall_mem) begin
                exp_rw    <= m_reg_write;
                exp_rd    <= m_rd;
                exp_load  <= m_mem_to_reg;
                exp_data  <= m_mem_to_reg ? shadow[addr_idx] : m_alu_out;
                exp_known <= !m_mem_to_reg || shadow_ok[addr_idx];
            end
            // Unstalled store updates the reference copy
            if (m_mem_write && !m_mem_read && !stall_mem) begin
                shadow[addr_idx]    <= m_mem_data;
                shadow_ok[addr_idx] <= 1'b1;
            end
        end
    end

    // Stage comes out of reset quiet and idle
    a_reset_idle: assert property (@(posedge clk)
        reset |=> !wb_reg_write && !stall_mem && state == mem_pkg::MS_IDLE)
        else begin
            err_count++;
            $error("[FAIL] %0t: stage not idle after reset", $time);
        end

    // Load issue stalls for exactly the wait states plus one
    a_load_stall: assert property (@(posedge clk) disable iff (reset)
        (state == mem_pkg::MS_IDLE && m_mem_read)
            |-> stall_mem [* (`DMEM_WAIT_STATES + 1)] ##1 !stall_mem)
        else begin
            err_count++;
            $error("[FAIL] %0t: load stall length is wrong", $time);
        end

    a_no_stall: assert property (@(posedge clk) disable iff (reset)
        !m_mem_read |-> !stall_mem) // Stores and ALU results pass straight through
        else begin
            err_count++;
            $error("[FAIL] %0t: stall raised without a load", $time);
        end

    a_bubble: assert property (@(posedge clk) disable iff (reset)
        stall_mem |=> !wb_reg_write)
        else begin
            err_count++;
            $error("[FAIL] %0t: write-back enabled after a stalled cycle", $time);
        end

    a_wb_ctrl: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> wb_reg_write == exp_rw && wb_rd == exp_rd)
        else begin
            err_count++;
            $error("[FAIL] %0t: wb_rd %0d wb_reg_write %0b, expected %0d %0b", $time,
                   $sampled(wb_rd), $sampled(wb_reg_write),
                   $sampled(exp_rd), $sampled(exp_rw));
        end

    a_wb_alu: assert property (@(posedge clk) disable iff (reset)
        exp_valid && !exp_load |-> wb_data == exp_data)
        else begin
            err_count++;
            $error("[FAIL] %0t: wb_data %h, expected ALU result %h", $time,
                   $sampled(wb_data), $sampled(exp_data));
        end

    a_wb_load: assert property (@(posedge clk) disable iff (reset)
        exp_valid && exp_load && exp_known |-> wb_data == exp_data)
        else begin
            err_count++;
            $error("[FAIL] %0t: wb_data %h, expected load word %h", $time,
                   $sampled(wb_data), $sampled(exp_data));
        end

endmodule

bind mem_stage mem_stage_assert u_assert (
    .clk          (clk),
    .reset        (reset),
    .m_mem_read   (m_mem_read),
    .m_mem_write  (m_mem_write),
    .m_mem_to_reg (m_mem_to_reg),
    .m_reg_write  (m_reg_write),
    .m_alu_out    (m_alu_out),
    .m_mem_data   (m_mem_data),
    .m_rd         (m_rd),
    .stall_mem    (stall_mem),
    .wb_data      (wb_data),
    .wb_rd        (wb_rd),
    .wb_reg_write (wb_reg_write),
    .state        (state)
);

// ==== dv/tb_mem_stage.sv ====
`timescale 1ns/1ps

`include "mem_config.svh"

module tb_mem_stage;

    localparam int NUM_INSTR  = 400;
    localparam int MAX_CYCLES = NUM_INSTR * (`DMEM_WAIT_STATES + 2) + 100; // Loads are longest

    logic              clk;
    logic              reset;
    logic              m_mem_read;
    logic              m_mem_write;
    logic              m_mem_to_reg;
    logic              m_reg_write;
    mem_pkg::word_t    m_alu_out;
    mem_pkg::word_t    m_mem_data;
    mem_pkg::reg_idx_t m_rd;
    logic              stall_mem;
    mem_pkg::word_t    wb_data;
    mem_pkg::reg_idx_t wb_rd;
    logic              wb_reg_write;

    logic [31:0]    rng_state = 32'h781244b7;
    mem_pkg::word_t stored_q [$];  // Addresses written so far
    int             cycle_count = 0;
    int             n_store = 0;
    int             n_load = 0;
    int             n_load_hit = 0; // Loads to a stored address
    int             n_alu = 0;
    int             errors;

    mem_stage uut (
        .clk          (clk),
        .reset        (reset),
        .m_mem_read   (m_mem_read),
        .m_mem_write  (m_mem_write),
        .m_mem_to_reg (m_mem_to_reg),
        .m_reg_write  (m_reg_write),
        .m_alu_out    (m_alu_out),
        .m_mem_data   (m_mem_data),
        .m_rd         (m_rd),
        .stall_mem    (stall_mem),
        .wb_data      (wb_data),
        .wb_rd        (wb_rd),
        .wb_reg_write (wb_reg_write)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Bubble, all controls low
    task automatic drive_idle();
        m_mem_read   = 1'b0;
        m_mem_write  = 1'b0;
        m_mem_to_reg = 1'b0;
        m_reg_write  = 1'b0;
        m_alu_out    = '0;
        m_mem_data   = '0;
        m_rd         = '0;
    endtask

    // Drive one random instruction and hold it until the stage accepts it
    task automatic send_instr();
        logic [31:0] r;
        rng_state = xorshift32(rng_state);
        r = rng_state;
        drive_idle();
        m_rd = r[12:8];
        if (r[2:0] < 3'd3) begin
            m_mem_write = 1'b1; // Store
            rng_state   = xorshift32(rng_state);
            m_alu_out   = rng_state;
            rng_state   = xorshift32(rng_state);
            m_mem_data  = rng_state;
            stored_q.push_back(m_alu_out);
            n_store++;
        end else if (r[2:0] < 3'd6) begin
            m_mem_read   = 1'b1; // Load, write back the memory word
            m_mem_to_reg = 1'b1;
            m_reg_write  = 1'b1;
            rng_state    = xorshift32(rng_state);
            if (stored_q.size() > 0 && r[6:3] != 4'd0) begin
                m_alu_out = stored_q[rng_state % stored_q.size()];
                n_load_hit++;
            end else begin
                m_alu_out = rng_state; // Rare load to a fresh address
            end
            n_load++;
        end else begin
            m_reg_write = r[7]; // ALU result only
            rng_state   = xorshift32(rng_state);
            m_alu_out   = rng_state;
            n_alu++;
        end
        // Stall is combinational, look at it mid-cycle
        @(negedge clk);
        while (stall_mem) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the stage stopped accepting instructions",
                     cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        drive_idle();
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        @(posedge clk); // Quiet cycle right after reset
        #1;
        for (int i = 0; i < NUM_INSTR; i++) begin
            send_instr();
        end
        drive_idle();
        repeat (3) @(posedge clk); // Let the last checks fire
        errors = uut.u_assert.err_count;
        if (n_load_hit == 0) begin
            $display("No load read back a stored address");
            errors++;
        end
        $display("Instructions %0d: stores %0d, loads %0d (%0d to stored data), alu %0d, errors %0d",
                 NUM_INSTR, n_store, n_load, n_load_hit, n_alu, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== include/mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Data memory timing

// Extra stall cycles a load spends beyond its issue cycle
// Zero is legal and leaves only the registered read cycle
`define DMEM_WAIT_STATES 2

// Data memory geometry

// Word index width inside one bank
// Four word-interleaved banks sit on address bits [3:2]
`define DMEM_INDEX_BITS 10

// Words held by each bank
`define DMEM_BANK_WORDS (1 << `DMEM_INDEX_BITS)

`endif

// ==== logic/bank_select_mux.sv ====
`timescale 1ns/1ps

`include "mem_config.svh"

module bank_select_mux (
    input  logic                        clk,
    input  logic                        reset,
    input  mem_pkg::mem_addr_u          addr,       // ALU result as address
    input  logic                        mem_write,  // Store request
    input  logic                        read_issue, // Load issue strobe
    input  mem_pkg::word_t              bank_rdata0,
    input  mem_pkg::word_t              bank_rdata1,
    input  mem_pkg::word_t              bank_rdata2,
    input  mem_pkg::word_t              bank_rdata3,
    output logic [3:0]                  bank_re,
    output logic [3:0]                  bank_we,
    output logic [`DMEM_INDEX_BITS-1:0] bank_index, // Shared by all banks
    output mem_pkg::word_t              read_word   // Word of the issued load
);

    logic [3:0] bank_hot; // One-hot bank decode
    logic [1:0] rd_bank;  // Bank of the outstanding load
    logic       store;

    assign bank_hot = 4'b0001 << addr.fields.bank;

    // A read issue wins over a store in the same cycle
    assign store = mem_write & ~read_issue;

    assign bank_re    = bank_hot & {4{read_issue}};
    assign bank_we    = bank_hot & {4{store}};
    assign bank_index = addr.fields.index;

    // Remember where the load went, the address may move on later
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_bank <= 2'd0;
        end else if (read_issue) begin
            rd_bank <= addr.fields.bank;
        end
    end

    // Return path
    always_comb begin
        case (rd_bank)
            2'd0:    read_word = bank_rdata0;
            2'd1:    read_word = bank_rdata1;
            2'd2:    read_word = bank_rdata2;
            default: read_word = bank_rdata3;
        endcase
    end

endmodule

// ==== logic/dmem_bank.sv ====
`timescale 1ns/1ps

`include "mem_config.svh"

module dmem_bank (
    input  logic                        clk,
    input  logic                        re,    // Capture a read word
    input  logic                        we,    // Write wdata at index
    input  logic [`DMEM_INDEX_BITS-1:0] index,
    input  mem_pkg::word_t              wdata,
    output mem_pkg::word_t              rdata  // Registered read port
);

    // Word array of one interleave bank
    mem_pkg::word_t mem [`DMEM_BANK_WORDS];

    // Synchronous write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    // Read register only moves on re
    // Holds the word while the stage waits out the load
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[index];
        end
    end

endmodule

// ==== logic/mem_access_fsm.sv ====
`timescale 1ns/1ps

module mem_access_fsm (
    input  logic                clk,
    input  logic                reset,
    input  logic                mem_read,    // Load request from EX/MEM
    input  logic                timer_last,  // Final wait cycle reached
    output logic                timer_start, // Loads the wait timer
    output logic                read_issue,  // Bank read strobe
    output logic                stall_mem,   // Holds EX/MEM upstream
    output mem_pkg::mem_state_e state        // Exported for checking
);

    mem_pkg::mem_state_e state_next;

    logic in_idle;
    logic in_wait;

    assign in_idle = (state == mem_pkg::MS_IDLE);
    assign in_wait = (state == mem_pkg::MS_LOAD_WAIT);

    // A load only starts from idle
    // The completion cycle sits in MS_LOAD_WAIT, so the held
    // mem_read does not issue a second time
    assign read_issue  = in_idle & mem_read;
    assign timer_start = read_issue;

    // Stall covers the issue cycle and every wait cycle
    // It drops in the last one, where the read word is valid
    assign stall_mem = read_issue | (in_wait & ~timer_last);

    always_comb begin
        state_next = state; // Hold by default
        case (state)
            mem_pkg::MS_IDLE: begin
                if (mem_read) begin
                    state_next = mem_pkg::MS_LOAD_WAIT;
                end
            end
            mem_pkg::MS_LOAD_WAIT: begin
                // Timer marks the cycle MEM/WB takes the word
                if (timer_last) begin
                    state_next = mem_pkg::MS_IDLE;
                end
            end
            default: begin
                state_next = mem_pkg::MS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mem_pkg::MS_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== logic/mem_pkg.sv ====
package mem_pkg;

    `include "mem_config.svh"

    // Datapath word
    typedef logic [31:0] word_t;

    // Destination register number
    typedef logic [4:0] reg_idx_t;

    // ALU result seen as a data memory address
    typedef struct packed {
        logic [31-`DMEM_INDEX_BITS-4:0] upper;  // Bits above the banked range
        logic [`DMEM_INDEX_BITS-1:0]    index;  // Word inside the bank
        logic [1:0]                     bank;   // Interleave select
        logic [1:0]                     offset; // Byte offset, ignored
    } mem_addr_fields_t;

    // Same ALU word, decoded two ways
    // The raw view goes to write-back, the field view drives the banks
    typedef union packed {
        word_t            raw;
        mem_addr_fields_t fields;
    } mem_addr_u;

    // Load sequencing
    typedef enum logic {
        MS_IDLE,      // Ready for the next access
        MS_LOAD_WAIT  // Load in flight, read word pending
    } mem_state_e;

endpackage

// ==== logic/mem_stage.sv ====
`timescale 1ns/1ps

`include "mem_config.svh"

module mem_stage (
    input  logic              clk,
    input  logic              reset,

    // From EX/MEM
    input  logic              m_mem_read,   // Load
    input  logic              m_mem_write,  // Store
    input  logic              m_mem_to_reg, // Write back memory word
    input  logic              m_reg_write,
    input  mem_pkg::word_t    m_alu_out,    // Address or ALU result
    input  mem_pkg::word_t    m_mem_data,   // Store data
    input  mem_pkg::reg_idx_t m_rd,

    // Back-pressure to EX/MEM
    output logic              stall_mem,

    // To write-back
    output mem_pkg::word_t    wb_data,
    output mem_pkg::reg_idx_t wb_rd,
    output logic              wb_reg_write
);

    mem_pkg::mem_addr_u          alu_addr; // Both views of m_alu_out
    mem_pkg::mem_state_e         state;
    mem_pkg::word_t              bank_rdata [4];
    mem_pkg::word_t              read_word;
    logic [`DMEM_INDEX_BITS-1:0] bank_index;
    logic [3:0]                  bank_re;
    logic [3:0]                  bank_we;
    logic                        timer_start;
    logic                        timer_last;
    logic                        read_issue;

    assign alu_addr = m_alu_out;

    // Load sequencing and stall
    mem_access_fsm u_fsm (
        .clk         (clk),
        .reset       (reset),
        .mem_read    (m_mem_read),
        .timer_last  (timer_last),
        .timer_start (timer_start),
        .read_issue  (read_issue),
        .stall_mem   (stall_mem),
        .state       (state)
    );

    mem_wait_timer u_timer (
        .clk   (clk),
        .reset (reset),
        .start (timer_start),
        .last  (timer_last)
    );

    // Bank decode and read return
    bank_select_mux u_sel (
        .clk         (clk),
        .reset       (reset),
        .addr        (alu_addr),
        .mem_write   (m_mem_write),
        .read_issue  (read_issue),
        .bank_rdata0 (bank_rdata[0]),
        .bank_rdata1 (bank_rdata[1]),
        .bank_rdata2 (bank_rdata[2]),
        .bank_rdata3 (bank_rdata[3]),
        .bank_re     (bank_re),
        .bank_we     (bank_we),
        .bank_index  (bank_index),
        .read_word   (read_word)
    );

    // Four word-interleaved banks
    for (genvar b = 0; b < 4; b++) begin : g_bank
        dmem_bank u_bank (
            .clk   (clk),
            .re    (bank_re[b]),
            .we    (bank_we[b]),
            .index (bank_index),
            .wdata (m_mem_data),
            .rdata (bank_rdata[b])
        );
    end

    // MEM/WB, raw address view doubles as the ALU result
    memwb_reg u_memwb (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall_mem),
        .mem_to_reg   (m_mem_to_reg),
        .reg_write    (m_reg_write),
        .alu_out      (alu_addr.raw),
        .read_word    (read_word),
        .rd           (m_rd),
        .wb_data      (wb_data),
        .wb_rd        (wb_rd),
        .wb_reg_write (wb_reg_write)
    );

endmodule

// ==== logic/mem_wait_timer.sv ====
`timescale 1ns/1ps

`include "mem_config.svh"

module mem_wait_timer (
    input  logic clk,
    input  logic reset,
    input  logic start, // Load the wait count
    output logic last   // Final cycle of the wait
);

    // One spare bit so a zero wait still has a counter
    localparam int CNT_W = $clog2(`DMEM_WAIT_STATES + 2);

    logic [CNT_W-1:0] count;
    logic             active; // Wait in progress

    // Count reaches zero in the cycle the load completes
    assign last = active & (count == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            count  <= '0;
            active <= 1'b0;
        end else if (start) begin
            count  <= CNT_W'(`DMEM_WAIT_STATES);
            active <= 1'b1;
        end else if (last) begin
            active <= 1'b0; // Wait done, back to idle
        end else if (active) begin
            count <= count - 1'b1;
        end
    end

endmodule

// ==== logic/memwb_reg.sv ====
`timescale 1ns/1ps

module memwb_reg (
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,        // MEM busy, nothing to pass on
    input  logic              mem_to_reg,   // Write back the load word
    input  logic              reg_write,
    input  mem_pkg::word_t    alu_out,
    input  mem_pkg::word_t    read_word,
    input  mem_pkg::reg_idx_t rd,
    output mem_pkg::word_t    wb_data,
    output mem_pkg::reg_idx_t wb_rd,
    output logic              wb_reg_write
);

    mem_pkg::word_t wb_sel;

    // Write-back source
    assign wb_sel = mem_to_reg ? read_word : alu_out;

    // Control bit, bubble on stall
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_reg_write <= 1'b0;
        end else if (stall) begin
            wb_reg_write <= 1'b0; // Same instruction is not written twice
        end else begin
            wb_reg_write <= reg_write;
        end
    end

    // Payload only moves on an unstalled cycle
    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_data <= wb_sel;
            wb_rd   <= rd;
        end
    end

endmodule

// ==== tb.f ====
+incdir+include
logic/mem_pkg.sv
logic/mem_access_fsm.sv
logic/mem_wait_timer.sv
logic/dmem_bank.sv
logic/bank_select_mux.sv
logic/memwb_reg.sv
logic/mem_stage.sv
dv/mem_stage_assert.sv
dv/tb_mem_stage.sv
